// ==== Bender.yml ====
package:
  name: spi_pollable_memory

sources:
  - files:
      - source/mem_geometry_pkg.sv
      - source/spi_frame_pkg.sv
      - source/spi_frame_slave.sv
      - source/bank_router.sv
      - source/memory_bank.sv
      - source/stream_reader.sv
      - source/spi_pollable_memory.sv
  - target: simulation
    files:
      - verif/spi_pollable_memory_asserts.sv
      - verif/tb_spi_pollable_memory.sv

// ==== compile.f ====
source/mem_geometry_pkg.sv
source/spi_frame_pkg.sv
source/spi_frame_slave.sv
source/bank_router.sv
source/memory_bank.sv
source/stream_reader.sv
source/spi_pollable_memory.sv
verif/spi_pollable_memory_asserts.sv
verif/tb_spi_pollable_memory.sv

// ==== source/bank_router.sv ====
// bank router
// range-checks the word address, selects a bank and swaps byte order so
// that lane 0 of a stored word is the first byte seen on SPI
`timescale 1ns/1ps

module bank_router import mem_geometry_pkg::*, spi_frame_pkg::*; (
	input logic clock50,
	input logic reset3,
	input spi_frame_t frame,
	input logic frame_valid,
	input logic header_valid,
	output data_word_t read_word,
	output logic [num_banks-1:0] wr_en,
	output word_index_t a_index,
	output data_word_t a_wdata,
	input data_word_t a_rdata [num_banks]
);

	logic in_range;
	bank_sel_t bank;
	logic rd_pending;
	logic rd_ok;
	bank_sel_t rd_bank;

	function automatic data_word_t swap_bytes(input data_word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	assign in_range = frame.addr < mem_words;
	assign bank = frame.addr[word_index_bits +: bank_index_bits];
	// address is held from the header to the end of the frame
	assign a_index = frame.addr[word_index_bits-1:0];

	always_ff @(posedge clock50) begin
		if (reset3) begin
			wr_en <= '0;
		end else begin
			wr_en <= '0;
			if (frame_valid && frame.cmd == cmd_write && in_range) begin
				wr_en[bank] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock50) begin
		if (frame_valid) begin
			a_wdata <= swap_bytes(frame.data);
		end
	end

	always_ff @(posedge clock50) begin
		if (reset3) begin
			rd_pending <= 1'b0;
		end else begin
			rd_pending <= header_valid;
		end
	end

	always_ff @(posedge clock50) begin
		if (header_valid) begin
			rd_bank <= bank;
			rd_ok <= in_range && frame.cmd == cmd_read;
		end
		// out of range or not a read gives zero
		if (rd_pending) begin
			read_word <= rd_ok ? swap_bytes(a_rdata[rd_bank]) : '0;
		end
	end

endmodule

// ==== source/mem_geometry_pkg.sv ====
// memory geometry
// four banks of 64 words, with the address split used by the router and the stream
package mem_geometry_pkg;

	localparam int num_banks = 4;
	localparam int bank_words = 64;
	localparam int bank_index_bits = 2;
	localparam int word_index_bits = 6;
	// byte lanes per 32-bit word
	localparam int lane_bits = 2;
	localparam int mem_words = num_banks * bank_words;
	localparam int mem_bytes = mem_words * 4;

	typedef logic [bank_index_bits-1:0] bank_sel_t;
	typedef logic [word_index_bits-1:0] word_index_t;
	typedef logic [word_index_bits+lane_bits-1:0] byte_index_t;
	typedef logic [bank_index_bits+word_index_bits+lane_bits-1:0] byte_addr_t;

endpackage

// ==== source/memory_bank.sv ====
// memory bank
// 64 x 32 dual-port RAM, whole words on port A and single bytes on port B
`timescale 1ns/1ps

module memory_bank import mem_geometry_pkg::*, spi_frame_pkg::*; (
	input logic clock50,
	input logic wr_en,
	input word_index_t a_index,
	input data_word_t a_wdata,
	output data_word_t a_rdata,
	input byte_index_t b_index,
	output byte_t b_rdata
);

	data_word_t mem [bank_words];
	word_index_t b_word;
	logic [lane_bits-1:0] b_lane;

	assign b_word = b_index[$bits(byte_index_t)-1 -: word_index_bits];
	assign b_lane = b_index[lane_bits-1:0];

	// read-before-write on port A
	always_ff @(posedge clock50) begin
		if (wr_en) begin
			mem[a_index] <= a_wdata;
		end
		a_rdata <= mem[a_index];
	end

	// lane 0 sits in the low byte
	always_ff @(posedge clock50) begin
		b_rdata <= mem[b_word][8*b_lane +: 8];
	end

endmodule

// ==== source/spi_frame_pkg.sv ====
// SPI frame definitions
// field types, command codes, the assembled frame and the outgoing stream beat
package spi_frame_pkg;

	import mem_geometry_pkg::*;

	typedef logic [7:0] cmd_t;
	typedef logic [15:0] word_addr_t;
	typedef logic [31:0] data_word_t;
	typedef logic [7:0] byte_t;

	localparam cmd_t cmd_write = 8'h57;
	localparam cmd_t cmd_read = 8'h52;

	// command byte, then address, then data word, all msb first
	localparam int frame_bits = 56;
	// bits before the data phase starts
	localparam int header_bits = 24;

	typedef struct packed {
		cmd_t cmd;
		word_addr_t addr;
		data_word_t data;
	} spi_frame_t;

	typedef struct packed {
		byte_addr_t addr;
		byte_t data;
	} stream_beat_t;

endpackage

// ==== source/spi_frame_slave.sv ====
// SPI frame slave
// oversamples SCLK with clock50, assembles 56-bit frames (mode 0) and
// shifts the read word back out on MISO during the data phase
`timescale 1ns/1ps

module spi_frame_slave import mem_geometry_pkg::*, spi_frame_pkg::*; (
	input logic clock50,
	input logic reset3,
	input logic sclk,
	input logic mosi,
	input logic ssel,
	output logic miso,
	output spi_frame_t frame,
	output logic frame_valid,
	output logic header_valid,
	input data_word_t read_word
);

	logic [2:0] sclk_sync;
	logic [1:0] mosi_sync;
	logic [1:0] ssel_sync;
	logic sclk_rise;
	logic sclk_fall;
	logic selected;
	logic [$clog2(frame_bits)-1:0] bit_count;
	logic [header_bits-1:0] header_sr;
	data_word_t data_sr;
	data_word_t miso_sr;
	logic [1:0] load_pipe;

	assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
	assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
	assign selected = ~ssel_sync[1];

	// header fields hold until the next frame and feed the router directly
	assign frame = {header_sr, data_sr};
	assign miso = miso_sr[$bits(data_word_t)-1];

	always_ff @(posedge clock50) begin
		if (reset3) begin
			sclk_sync <= '0;
			mosi_sync <= '0;
			ssel_sync <= '1;
		end else begin
			sclk_sync <= {sclk_sync[1:0], sclk};
			mosi_sync <= {mosi_sync[0], mosi};
			ssel_sync <= {ssel_sync[0], ssel};
		end
	end

	always_ff @(posedge clock50) begin
		if (reset3) begin
			bit_count <= '0;
			frame_valid <= 1'b0;
			header_valid <= 1'b0;
		end else begin
			frame_valid <= 1'b0;
			header_valid <= 1'b0;
			// deselect drops a partial frame
			if (!selected) begin
				bit_count <= '0;
			end else if (sclk_rise) begin
				if (bit_count == frame_bits - 1) begin
					bit_count <= '0;
					frame_valid <= 1'b1;
				end else begin
					bit_count <= bit_count + 1'b1;
				end
				if (bit_count == header_bits - 1) begin
					header_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock50) begin
		if (selected && sclk_rise) begin
			if (bit_count < header_bits) begin
				header_sr <= {header_sr[header_bits-2:0], mosi_sync[1]};
			end else begin
				data_sr <= {data_sr[$bits(data_word_t)-2:0], mosi_sync[1]};
			end
		end
	end

	// read word is loaded before the master samples the first data bit
	always_ff @(posedge clock50) begin
		if (reset3) begin
			load_pipe <= '0;
			miso_sr <= '0;
		end else begin
			load_pipe <= {load_pipe[0], header_valid};
			if (load_pipe[1]) begin
				miso_sr <= read_word;
			end else if (selected && sclk_fall && bit_count > header_bits) begin
				miso_sr <= {miso_sr[$bits(data_word_t)-2:0], 1'b0};
			end
		end
	end

endmodule

// ==== source/spi_pollable_memory.sv ====
// SPI pollable memory
// SPI slave and router in front of four RAM banks, with a free-running
// byte stream reading the banks out continuously
`timescale 1ns/1ps

module spi_pollable_memory import mem_geometry_pkg::*, spi_frame_pkg::*; (
	input logic clock50,
	input logic reset3,
	input logic sclk,
	input logic mosi,
	input logic ssel,
	output logic miso,
	output stream_beat_t stream,
	output logic stream_valid
);

	spi_frame_t frame;
	logic frame_valid;
	logic header_valid;
	data_word_t read_word;
	logic [num_banks-1:0] wr_en;
	word_index_t a_index;
	data_word_t a_wdata;
	data_word_t a_rdata [num_banks];
	byte_index_t b_index;
	byte_t b_rdata [num_banks];

	spi_frame_slave u_spi_frame_slave (
		.clock50 (clock50),
		.reset3 (reset3),
		.sclk (sclk),
		.mosi (mosi),
		.ssel (ssel),
		.miso (miso),
		.frame (frame),
		.frame_valid (frame_valid),
		.header_valid (header_valid),
		.read_word (read_word)
	);

	bank_router u_bank_router (
		.clock50 (clock50),
		.reset3 (reset3),
		.frame (frame),
		.frame_valid (frame_valid),
		.header_valid (header_valid),
		.read_word (read_word),
		.wr_en (wr_en),
		.a_index (a_index),
		.a_wdata (a_wdata),
		.a_rdata (a_rdata)
	);

	for (genvar g = 0; g < num_banks; g++) begin : g_bank
		memory_bank u_memory_bank (
			.clock50 (clock50),
			.wr_en (wr_en[g]),
			.a_index (a_index),
			.a_wdata (a_wdata),
			.a_rdata (a_rdata[g]),
			.b_index (b_index),
			.b_rdata (b_rdata[g])
		);
	end

	stream_reader u_stream_reader (
		.clock50 (clock50),
		.reset3 (reset3),
		.b_index (b_index),
		.b_rdata (b_rdata),
		.stream (stream),
		.stream_valid (stream_valid)
	);

endmodule

// ==== source/stream_reader.sv ====
// stream reader
// walks all byte addresses one per clock and puts each byte with its address
// on the stream output, two cycles after the counter value
`timescale 1ns/1ps

module stream_reader import mem_geometry_pkg::*, spi_frame_pkg::*; (
	input logic clock50,
	input logic reset3,
	output byte_index_t b_index,
	input byte_t b_rdata [num_banks],
	output stream_beat_t stream,
	output logic stream_valid
);

	byte_addr_t count;
	byte_addr_t addr_d;
	bank_sel_t bank_d;
	logic valid_d;

	// low bits go to every bank and the top bits pick the bank a cycle later
	assign b_index = count[$bits(byte_index_t)-1:0];
	assign bank_d = addr_d[$bits(byte_addr_t)-1 -: bank_index_bits];

	always_ff @(posedge clock50) begin
		if (reset3) begin
			count <= '0;
			valid_d <= 1'b0;
			stream_valid <= 1'b0;
		end else begin
			if (count == byte_addr_t'(mem_bytes - 1)) begin
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
			valid_d <= 1'b1;
			stream_valid <= valid_d;
		end
	end

	always_ff @(posedge clock50) begin
		addr_d <= count;
		stream.addr <= addr_d;
		stream.data <= b_rdata[bank_d];
	end

endmodule

// ==== verif/spi_golden.txt ====
# columns: name, command, word address, data word, expected read word, frame bits
# all hex except frame bits; words not written here hold the fill pattern
wr_same 57 0005 11223344 00000000 56
rd_same 52 0005 00000000 11223344 56
wr_bank0 57 0010 a0a1a2a3 00000000 56
wr_bank1 57 0050 b0b1b2b3 00000000 56
wr_bank2 57 0090 c0c1c2c3 00000000 56
wr_bank3 57 00d0 d0d1d2d3 00000000 56
rd_bank0 52 0010 00000000 a0a1a2a3 56
rd_bank1 52 0050 00000000 b0b1b2b3 56
rd_bank2 52 0090 00000000 c0c1c2c3 56
rd_bank3 52 00d0 00000000 d0d1d2d3 56
wr_top 57 00ff 0badf00d 00000000 56
rd_top 52 00ff 00000000 0badf00d 56
wr_oor 57 0140 deadbeef 00000000 56
rd_oor 52 0140 00000000 00000000 56
rd_alias 52 0040 00000000 40bf1a51 56
rd_edge 52 0100 00000000 00000000 56
rd_max 52 ffff 00000000 00000000 56
unk_cmd 41 0021 cafef00d 00000000 56
rd_unk 52 0021 00000000 21de7b32 56
short_wr 57 0033 feedface 00000000 40
rd_short 52 0033 00000000 33cc6944 56
rewrite 57 0005 55667788 00000000 56
rd_rewrite 52 0005 00000000 55667788 56

// ==== verif/spi_pollable_memory_asserts.sv ====
// protocol assertions for the SPI pollable memory
// frame pulse width, write enable decoding and the stream address sequence
`timescale 1ns/1ps

module spi_pollable_memory_asserts import mem_geometry_pkg::*, spi_frame_pkg::*; (
	input logic clock50,
	input logic reset3,
	input logic frame_valid,
	input logic [num_banks-1:0] wr_en,
	input stream_beat_t stream,
	input logic stream_valid
);

	// failed assertion count
	int assert_failures = 0;

	frame_pulse: assert property (@(posedge clock50) disable iff (reset3)
		frame_valid |=> !frame_valid)
		else begin
			$error("frame_valid stayed high for more than one cycle");
			assert_failures++;
		end

	wr_en_onehot: assert property (@(posedge clock50) disable iff (reset3)
		$onehot0(wr_en))
		else begin
			$error("more than one bank write enable active");
			assert_failures++;
		end

	// first beat after reset starts at byte 0
	stream_start: assert property (@(posedge clock50) disable iff (reset3)
		stream_valid && !$past(stream_valid) |-> stream.addr == '0)
		else begin
			$error("first stream beat does not start at address 0");
			assert_failures++;
		end

	stream_step: assert property (@(posedge clock50) disable iff (reset3)
		stream_valid && $past(stream_valid) |->
		stream.addr == byte_addr_t'($past(stream.addr) + 1'b1))
		else begin
			$error("stream address did not advance by one");
			assert_failures++;
		end

endmodule

bind spi_pollable_memory spi_pollable_memory_asserts u_spi_pollable_memory_asserts (
	.clock50 (clock50),
	.reset3 (reset3),
	.frame_valid (frame_valid),
	.wr_en (wr_en),
	.stream (stream),
	.stream_valid (stream_valid)
);

// ==== verif/tb_spi_pollable_memory.sv ====
// testbench for the SPI pollable memory
// plays the golden frames over SPI, keeps a word model of the memory and
// checks MISO read-backs and one full wrap of the byte stream
`timescale 1ns/1ps

module tb_spi_pollable_memory import mem_geometry_pkg::*, spi_frame_pkg::*; ();

	typedef logic [8*24-1:0] test_name_t;
	localparam int max_tests = 64;

	logic clock50;
	logic reset3;
	logic sclk;
	logic mosi;
	logic ssel;
	logic miso;
	stream_beat_t stream;
	logic stream_valid;

	test_name_t test_name [max_tests];
	spi_frame_t test_frame [max_tests];
	data_word_t test_expect [max_tests];
	int test_bits [max_tests];
	int num_tests = 0;
	data_word_t model [mem_words];
	int errors = 0;
	int passed = 0;
	int failed = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	spi_pollable_memory u_spi_pollable_memory (
		.clock50 (clock50),
		.reset3 (reset3),
		.sclk (sclk),
		.mosi (mosi),
		.ssel (ssel),
		.miso (miso),
		.stream (stream),
		.stream_valid (stream_valid)
	);

	initial begin
		clock50 = 1'b0;
		forever #4 clock50 = ~clock50;
	end

	initial begin
		wait (cycle_limit != 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clock50);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("Simulation failed");
		$finish;
	end

	// initial contents differ for every word address
	function automatic data_word_t fill_word(input int a);
		byte_t b;
		b = byte_t'(a);
		return {b, ~b, b ^ 8'h5a, byte_t'(b + 8'h11)};
	endfunction

	task automatic check_word(input test_name_t name, input data_word_t expected,
			input data_word_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %0s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_byte(input test_name_t name, input byte_t expected,
			input byte_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %0s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic report_test(input test_name_t name, input int errors_before);
		if (errors == errors_before) begin
			$display("test %0s passed", name);
			passed++;
		end else begin
			$display("test %0s failed", name);
			failed++;
		end
	endtask

	task automatic load_golden();
		int fd;
		int code;
		test_name_t tok;
		logic [8*120-1:0] rest;
		cmd_t c;
		word_addr_t a;
		data_word_t d;
		data_word_t e;
		int b;
		fd = $fopen("verif/spi_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open the golden file verif/spi_golden.txt");
			errors++;
			return;
		end
		while (!$feof(fd) && num_tests < max_tests) begin
			tok = '0;
			code = $fscanf(fd, "%s", tok);
			if (code == 1 && tok == "#") begin
				code = $fgets(rest, fd);
			end else if (code == 1) begin
				code = $fscanf(fd, "%h %h %h %h %d", c, a, d, e, b);
				if (code == 5) begin
					test_name[num_tests] = tok;
					test_frame[num_tests] = '{cmd: c, addr: a, data: d};
					test_expect[num_tests] = e;
					test_bits[num_tests] = b;
					num_tests++;
				end else begin
					$display("malformed line in the golden file at test %0s", tok);
					errors++;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic spi_transfer(input spi_frame_t tx, input int bits, output data_word_t rx);
		data_word_t captured;
		captured = '0;
		@(posedge clock50);
		ssel <= 1'b0;
		repeat (3) @(posedge clock50);
		for (int i = 0; i < bits; i++) begin
			// mode 0 so data changes while SCLK is low
			@(posedge clock50);
			sclk <= 1'b0;
			mosi <= tx[frame_bits-1-i];
			repeat (3) @(posedge clock50);
			@(negedge clock50);
			if (i >= header_bits) begin
				captured = {captured[30:0], miso};
			end
			@(posedge clock50);
			sclk <= 1'b1;
			repeat (3) @(posedge clock50);
		end
		@(posedge clock50);
		sclk <= 1'b0;
		repeat (3) @(posedge clock50);
		ssel <= 1'b1;
		repeat (8) @(posedge clock50);
		rx = captured;
	endtask

	task automatic fill_memory();
		spi_frame_t f;
		data_word_t rx;
		for (int a = 0; a < mem_words; a++) begin
			f = '{cmd: cmd_write, addr: word_addr_t'(a), data: fill_word(a)};
			spi_transfer(f, frame_bits, rx);
			model[a] = fill_word(a);
		end
		$display("memory filled with %0d words", mem_words);
	endtask

	task automatic run_test(input int t);
		spi_frame_t f;
		data_word_t rx;
		data_word_t model_word;
		int errors_before;
		f = test_frame[t];
		errors_before = errors;
		spi_transfer(f, test_bits[t], rx);
		if (test_bits[t] == frame_bits && f.cmd == cmd_read) begin
			model_word = (f.addr < mem_words) ? model[f.addr] : '0;
			if (model_word !== test_expect[t]) begin
				$display("golden value of test %0s disagrees with the memory model",
					test_name[t]);
				errors++;
			end
			check_word(test_name[t], test_expect[t], rx);
		end
		// only complete in-range write frames change the memory
		if (test_bits[t] == frame_bits && f.cmd == cmd_write && f.addr < mem_words) begin
			model[f.addr] = f.data;
		end
		report_test(test_name[t], errors_before);
	endtask

	task automatic check_stream();
		stream_beat_t beat;
		data_word_t w;
		int seen;
		int errors_before;
		seen = 0;
		errors_before = errors;
		while (seen < mem_bytes) begin
			@(negedge clock50);
			if (stream_valid) begin
				beat = stream;
				// lane 0 is the first byte sent on SPI
				w = model[beat.addr >> lane_bits];
				check_byte("stream_wrap", w[8*(3 - beat.addr[1:0]) +: 8], beat.data);
				seen++;
			end
		end
		report_test("stream_wrap", errors_before);
	endtask

	initial begin
		reset3 <= 1'b1;
		sclk <= 1'b0;
		mosi <= 1'b0;
		ssel <= 1'b1;
		load_golden();
		// frames take under 600 cycles each plus reset and one stream wrap
		cycle_limit = (num_tests + mem_words) * 600 + 3000;
		repeat (16) @(posedge clock50);
		reset3 <= 1'b0;
		fill_memory();
		for (int t = 0; t < num_tests; t++) begin
			run_test(t);
		end
		check_stream();
		errors += u_spi_pollable_memory.u_spi_pollable_memory_asserts.assert_failures;
		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			passed + failed, passed, failed, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
